// File: Makefile
# Verilator build and run of the UART testbench
# "make run" compiles first and fails unless the log holds the pass line

TOP := uart_tb

.PHONY: all compile run clean

all: run

# timing support for the testbench delays, assertions for the bound checker
compile:
	verilator --binary --timing --assert --top-module $(TOP) -f build.f

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "=== PASS ===" sim.log

clean:
	rm -rf obj_dir sim.log

// File: build.f
source/uart_pkg.sv
source/byte_fifo.sv
source/uart_rx.sv
source/uart_tx.sv
source/uart_top.sv
sim/uart_chk.sv
sim/uart_tb.sv

// File: sim/uart_chk.sv
// assertion checker for the UART top, attached to every uart_top by the bind below
// watches the FIFO flags against their levels and the idle transmit line

`timescale 1ns/1ps

module uart_chk
  import uart_pkg::*;
(
  input logic               clk,
  input logic               rst,
  input logic               i_tx_full,
  input logic [LEVEL_W-1:0] i_tx_level,
  input logic               i_tx_empty,
  input tx_state_t          i_tx_state,
  input logic               i_txd,
  input logic               i_rx_empty,
  input logic [LEVEL_W-1:0] i_rx_level
);

  a_rx_empty: assert property (@(posedge clk) disable iff (rst)
    i_rx_empty == (i_rx_level == '0))
    else $error("o_rx_empty disagrees with o_rx_level %0d", i_rx_level);

  a_tx_full: assert property (@(posedge clk) disable iff (rst)
    i_tx_full == (i_tx_level == LEVEL_W'(FIFO_DEPTH)))
    else $error("o_tx_full disagrees with o_tx_level %0d", i_tx_level);

  a_levels: assert property (@(posedge clk) disable iff (rst)
    (i_tx_level <= LEVEL_W'(FIFO_DEPTH)) && (i_rx_level <= LEVEL_W'(FIFO_DEPTH)))
    else $error("FIFO level above depth, tx %0d rx %0d", i_tx_level, i_rx_level);

  // nothing to send means the line rests high
  a_txd_idle: assert property (@(posedge clk) disable iff (rst)
    (i_tx_empty && (i_tx_state == TX_IDLE)) |-> i_txd)
    else $error("o_txd low while the transmitter is idle with an empty FIFO");

endmodule

bind uart_top uart_chk u_chk (
  .clk        (clk),
  .rst        (rst),
  .i_tx_full  (o_tx_full),
  .i_tx_level (o_tx_level),
  .i_tx_empty (tx_fifo_empty),
  .i_tx_state (u_tx.state),
  .i_txd      (o_txd),
  .i_rx_empty (o_rx_empty),
  .i_rx_level (o_rx_level)
);

// File: sim/uart_tb.sv
// directed testbench for the UART core with loopback and line-driven frames through uart_top
// run with uart_tb as the top module and read the counts and the verdict on the closing lines

`timescale 1ns/1ps

module uart_tb
  import uart_pkg::*;
();

  localparam int CLK_PERIOD  = 40;
  localparam int BAUD_DIV    = 16;
  localparam int FRAME_CYC   = FRAME_BITS * BAUD_DIV;
  // frames put on the line by all tests, and idle gaps between them in frame times
  localparam int TEST_FRAMES = 8 + 10 + 2 + 18 + FIFO_DEPTH + 1;
  localparam int IDLE_FRAMES = 9;

  logic               clk;
  logic               rst;
  logic [DATA_W-1:0]  tx_data;
  logic               tx_write;
  logic               rx_read;
  logic               rxd;
  logic               tb_rxd;
  logic               loop_sel;
  logic               tx_full;
  logic [LEVEL_W-1:0] tx_level;
  logic               txd;
  logic [DATA_W-1:0]  rx_data;
  logic               rx_empty;
  logic [LEVEL_W-1:0] rx_level;
  logic [31:0]        rng_state;
  int                 errors;
  int                 err_at_start;
  int                 tests_run;
  int                 tests_failed;

  // the receiver listens either to its own transmitter or to a line driven here
  assign rxd = loop_sel ? txd : tb_rxd;

  uart_top UUT (
    .clk        (clk),
    .rst        (rst),
    .i_clkdiv   (CLKDIV_W'(BAUD_DIV)),
    .i_tx_data  (tx_data),
    .i_tx_write (tx_write),
    .i_rx_read  (rx_read),
    .i_rxd      (rxd),
    .o_tx_full  (tx_full),
    .o_tx_level (tx_level),
    .o_txd      (txd),
    .o_rx_data  (rx_data),
    .o_rx_empty (rx_empty),
    .o_rx_level (rx_level)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #((TEST_FRAMES + IDLE_FRAMES) * FRAME_CYC * CLK_PERIOD * 2 + 50 * CLK_PERIOD);
    $display("ERROR: watchdog expired before the tests finished");
    $display("=== FAIL ===");
    $finish;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic next_byte(output logic [DATA_W-1:0] b);
    rng_state = xorshift32(rng_state);
    b = rng_state[DATA_W-1:0];
  endtask

  task automatic check_byte(input string name, input logic [DATA_W-1:0] exp,
                            input logic [DATA_W-1:0] act);
    if (act !== exp) begin
      $display("CHECK FAILED %s: expected 8'h%02h, actual 8'h%02h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_level(input string name, input logic [LEVEL_W-1:0] exp,
                             input logic [LEVEL_W-1:0] act);
    if (act !== exp) begin
      $display("CHECK FAILED %s: expected level %0d, actual level %0d", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("CHECK FAILED %s: expected flag %0b, actual flag %0b", name, exp, act);
      errors++;
    end
  endtask

  task automatic report_error(input string name, input string msg);
    $display("ERROR %s: %s", name, msg);
    errors++;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == err_at_start) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - err_at_start);
    end
    err_at_start = errors;
  endtask

  // waits for room in the tx FIFO, then holds the write strobe for one cycle
  task automatic push_byte(input logic [DATA_W-1:0] b);
    @(negedge clk);
    while (tx_full) begin
      tx_write = 1'b0;
      @(negedge clk);
    end
    tx_data  = b;
    tx_write = 1'b1;
  endtask

  task automatic end_writes();
    @(negedge clk);
    tx_write = 1'b0;
  endtask

  // head entry is on o_rx_data before the pop
  task automatic pop_byte(output logic [DATA_W-1:0] b);
    @(negedge clk);
    b       = rx_data;
    rx_read = 1'b1;
    @(negedge clk);
    rx_read = 1'b0;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic wait_rx_level(input string name, input logic [LEVEL_W-1:0] target,
                               input int frames);
    int limit;
    int n;
    limit = (frames + 1) * FRAME_CYC;
    n = 0;
    while ((rx_level < target) && (n < limit)) begin
      @(negedge clk);
      n++;
    end
    if (rx_level < target) begin
      report_error(name, $sformatf("o_rx_level stayed at %0d, short of %0d, for %0d frame times",
                                   rx_level, target, frames + 1));
    end
  endtask

  // start bit, eight data bits LSB first, then the given stop bit, then idle high
  task automatic drive_line_frame(input logic [DATA_W-1:0] b, input logic stop_bit);
    logic [FRAME_BITS-1:0] bits;
    int i;
    bits = {stop_bit, b, 1'b0};
    for (i = 0; i < FRAME_BITS; i++) begin
      @(negedge clk);
      tb_rxd = bits[i];
      repeat (BAUD_DIV - 1) @(negedge clk);
    end
    @(negedge clk);
    tb_rxd = 1'b1;
  endtask

  task automatic reset_state();
    check_flag("reset_state", 1'b1, txd);
    check_flag("reset_state", 1'b1, rx_empty);
    check_flag("reset_state", 1'b0, tx_full);
    check_level("reset_state", '0, tx_level);
    check_level("reset_state", '0, rx_level);
    end_test("reset_state");
  endtask

  task automatic loopback_single();
    logic [DATA_W-1:0] sent;
    logic [DATA_W-1:0] got;
    int i;
    for (i = 0; i < 8; i++) begin
      next_byte(sent);
      push_byte(sent);
      end_writes();
      wait_rx_level("loopback_single", LEVEL_W'(1), 1);
      pop_byte(got);
      check_byte("loopback_single", sent, got);
      check_level("loopback_single", '0, rx_level);
    end
    end_test("loopback_single");
  endtask

  task automatic burst_in_order();
    logic [DATA_W-1:0] sent[$];
    logic [DATA_W-1:0] b;
    int i;
    for (i = 0; i < 10; i++) begin
      next_byte(b);
      sent.push_back(b);
      push_byte(b);
    end
    end_writes();
    wait_rx_level("burst_in_order", LEVEL_W'(10), 10);
    wait_cycles(BAUD_DIV);
    check_level("burst_in_order", LEVEL_W'(10), rx_level);
    for (i = 0; i < 10; i++) begin
      pop_byte(b);
      check_byte("burst_in_order", sent[i], b);
    end
    check_level("burst_in_order", '0, rx_level);
    end_test("burst_in_order");
  endtask

  task automatic framing_error();
    logic [DATA_W-1:0] b;
    logic [DATA_W-1:0] got;
    @(negedge clk);
    tb_rxd   = 1'b1;
    loop_sel = 1'b0;
    next_byte(b);
    drive_line_frame(b, 1'b0);
    wait_cycles(2 * FRAME_CYC);
    check_level("framing_error", '0, rx_level);
    // a clean frame right after must still come through
    next_byte(b);
    drive_line_frame(b, 1'b1);
    wait_rx_level("framing_error", LEVEL_W'(1), 1);
    pop_byte(got);
    check_byte("framing_error", b, got);
    check_level("framing_error", '0, rx_level);
    end_test("framing_error");
  endtask

  task automatic rx_overflow();
    logic [DATA_W-1:0] sent[$];
    logic [DATA_W-1:0] b;
    int i;
    @(negedge clk);
    loop_sel = 1'b1;
    for (i = 0; i < 18; i++) begin
      next_byte(b);
      sent.push_back(b);
      push_byte(b);
    end
    end_writes();
    wait_rx_level("rx_overflow", LEVEL_W'(FIFO_DEPTH), 18);
    // the last two frames are still on the line and have to be dropped
    wait_cycles(3 * FRAME_CYC);
    check_level("rx_overflow", '0, tx_level);
    check_level("rx_overflow", LEVEL_W'(FIFO_DEPTH), rx_level);
    for (i = 0; i < FIFO_DEPTH; i++) begin
      pop_byte(b);
      check_byte("rx_overflow", sent[i], b);
    end
    end_test("rx_overflow");
  endtask

  task automatic tx_full_fill();
    logic [DATA_W-1:0] accepted[$];
    logic [DATA_W-1:0] b;
    int n;
    int i;
    int exp_n;
    @(negedge clk);
    tb_rxd   = 1'b1;
    loop_sel = 1'b0;
    n = 0;
    while (!tx_full && (n < 4 * FIFO_DEPTH)) begin
      next_byte(b);
      accepted.push_back(b);
      tx_data  = b;
      tx_write = 1'b1;
      @(negedge clk);
      n++;
    end
    tx_write = 1'b0;
    if (!tx_full) begin
      report_error("tx_full_fill", "o_tx_full never rose while writing every cycle");
    end
    // one more write into the full FIFO, which must be ignored
    next_byte(b);
    tx_data  = b;
    tx_write = 1'b1;
    @(negedge clk);
    tx_write = 1'b0;
    check_flag("tx_full_fill", 1'b1, tx_full);
    check_level("tx_full_fill", LEVEL_W'(FIFO_DEPTH), tx_level);
    // the first frame went out while the line was held high so loopback resumes with the next one
    n = 0;
    while ((tx_level == LEVEL_W'(FIFO_DEPTH)) && (n < 2 * FRAME_CYC)) begin
      @(negedge clk);
      n++;
    end
    if (tx_level == LEVEL_W'(FIFO_DEPTH)) begin
      report_error("tx_full_fill", "the transmitter took no byte from the full FIFO");
    end
    loop_sel = 1'b1;
    exp_n = accepted.size() - 1;
    if (exp_n > FIFO_DEPTH) begin
      exp_n = FIFO_DEPTH;
    end
    wait_rx_level("tx_full_fill", LEVEL_W'(exp_n), exp_n + 1);
    wait_cycles((accepted.size() - exp_n) * FRAME_CYC);
    check_level("tx_full_fill", LEVEL_W'(exp_n), rx_level);
    for (i = 0; i < exp_n; i++) begin
      pop_byte(b);
      check_byte("tx_full_fill", accepted[i + 1], b);
    end
    check_level("tx_full_fill", '0, rx_level);
    end_test("tx_full_fill");
  endtask

  initial begin
    rst          = 1'b1;
    tx_data      = '0;
    tx_write     = 1'b0;
    rx_read      = 1'b0;
    tb_rxd       = 1'b1;
    loop_sel     = 1'b1;
    rng_state    = 32'd71;
    errors       = 0;
    err_at_start = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (10) @(negedge clk);
    rst = 1'b0;
    reset_state();
    loopback_single();
    burst_in_order();
    framing_error();
    rx_overflow();
    tx_full_fill();
    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: source/byte_fifo.sv
// first-word-fall-through byte FIFO with an occupancy count
// one instance sits on each side of the UART, the head entry is always on o_rd_data

`timescale 1ns/1ps

module byte_fifo
  import uart_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  logic [DATA_W-1:0]  i_wr_data,
  input  logic               i_wr,
  input  logic               i_rd,
  output logic [DATA_W-1:0]  o_rd_data,
  output logic               o_empty,
  output logic               o_full,
  output logic [LEVEL_W-1:0] o_level
);

  logic [DATA_W-1:0]  mem [FIFO_DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [LEVEL_W-1:0] count;
  logic               do_wr;
  logic               do_rd;

  // a write while full and a read while empty are both ignored
  assign do_wr = i_wr & ~o_full;
  assign do_rd = i_rd & ~o_empty;

  // storage, pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= i_wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // a simultaneous push and pop leaves the count where it is
      if (do_wr && !do_rd) begin
        count <= count + 1'b1;
      end else if (do_rd && !do_wr) begin
        count <= count - 1'b1;
      end
    end
  end

  // head entry is read combinationally so the consumer needs no extra cycle
  assign o_rd_data = mem[rd_ptr];
  assign o_empty   = (count == '0);
  assign o_full    = (count == LEVEL_W'(FIFO_DEPTH));
  assign o_level   = count;

endmodule

// File: source/uart_pkg.sv
// shared constants and state encodings for the UART core
// imported by the FIFO, the receiver, the transmitter, the top and the testbench

package uart_pkg;

  // character and frame geometry
  localparam int DATA_W     = 8;
  localparam int FRAME_BITS = 10;

  // FIFO sizing, a level must be able to hold FIFO_DEPTH itself
  localparam int FIFO_DEPTH = 16;
  localparam int PTR_W      = $clog2(FIFO_DEPTH);
  localparam int LEVEL_W    = PTR_W + 1;

  // baud divisor and bit counter widths
  localparam int CLKDIV_W   = 16;
  localparam int BITCNT_W   = 4;

  // receiver sequencing, RX_DATA spans the start bit and the eight data bits
  typedef enum logic [1:0] {
    RX_IDLE,
    RX_DATA,
    RX_STOP
  } rx_state_t;

  // transmitter sequencing, one state per part of the frame
  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } tx_state_t;

endpackage

// File: source/uart_rx.sv
// serial receiver, 8N1 framing with the bit period set by i_clkdiv
// samples each bit at its mid-point and pushes frames with a good stop bit into its FIFO

`timescale 1ns/1ps

module uart_rx
  import uart_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic [CLKDIV_W-1:0] i_clkdiv,
  input  logic                i_rxd,
  input  logic                i_fifo_full,
  output logic                o_fifo_wr,
  output logic [DATA_W-1:0]   o_fifo_data
);

  rx_state_t           state;
  logic                rx_meta;
  logic                rx_sync;
  logic [CLKDIV_W-1:0] baud_ctr;
  logic [BITCNT_W-1:0] bit_ctr;
  logic [DATA_W-1:0]   sr;
  logic                fall;
  logic                shift_now;
  logic                bit_end;

  // two-stage synchronizer, both stages idle high like the line
  always_ff @(posedge clk) begin
    if (rst) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= i_rxd;
      rx_sync <= rx_meta;
    end
  end

  // older stage high and newer stage low marks the leading edge of a start bit
  assign fall = rx_sync & ~rx_meta;

  // mid-bit sample point and end of a bit period
  assign shift_now = (state != RX_IDLE) && (baud_ctr == (i_clkdiv >> 1));
  assign bit_end   = (state != RX_IDLE) && (baud_ctr >= i_clkdiv);

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= RX_IDLE;
      baud_ctr <= '0;
      bit_ctr  <= '0;
    end else begin
      case (state)
        RX_IDLE: begin
          if (fall) begin
            state    <= RX_DATA;
            baud_ctr <= CLKDIV_W'(1);
            bit_ctr  <= BITCNT_W'(1);
          end
        end
        RX_DATA: begin
          if (bit_end) begin
            baud_ctr <= CLKDIV_W'(1);
            bit_ctr  <= bit_ctr + 1'b1;
            // the last data bit has ended, the next period is the stop bit
            if (bit_ctr == BITCNT_W'(FRAME_BITS - 1)) begin
              state <= RX_STOP;
            end
          end else begin
            baud_ctr <= baud_ctr + 1'b1;
          end
        end
        RX_STOP: begin
          // only the first half of the stop bit is needed
          if (shift_now) begin
            state    <= RX_IDLE;
            baud_ctr <= '0;
            bit_ctr  <= '0;
          end else begin
            baud_ctr <= baud_ctr + 1'b1;
          end
        end
        default: begin
          state <= RX_IDLE;
        end
      endcase
    end
  end

  // the start bit enters first and has been shifted out by the eighth data bit
  always_ff @(posedge clk) begin
    if ((state == RX_DATA) && shift_now) begin
      sr <= {rx_sync, sr[DATA_W-1:1]};
    end
  end

  // bad stop bit or no room in the FIFO drops the byte without a trace
  assign o_fifo_wr   = (state == RX_STOP) && shift_now && rx_sync && !i_fifo_full;
  assign o_fifo_data = sr;

endmodule

// File: source/uart_top.sv
// UART subsystem top with a byte FIFO in each direction
// the host pushes transmit bytes and pops received bytes, i_clkdiv sets the bit period

`timescale 1ns/1ps

module uart_top
  import uart_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic [CLKDIV_W-1:0] i_clkdiv,
  input  logic [DATA_W-1:0]   i_tx_data,
  input  logic                i_tx_write,
  input  logic                i_rx_read,
  input  logic                i_rxd,
  output logic                o_tx_full,
  output logic [LEVEL_W-1:0]  o_tx_level,
  output logic                o_txd,
  output logic [DATA_W-1:0]   o_rx_data,
  output logic                o_rx_empty,
  output logic [LEVEL_W-1:0]  o_rx_level
);

  logic              tx_fifo_rd;
  logic              tx_fifo_empty;
  logic [DATA_W-1:0] tx_fifo_data;
  logic              rx_fifo_wr;
  logic              rx_fifo_full;
  logic [DATA_W-1:0] rx_fifo_data;

  // transmit path, host side writes and the transmitter pops
  byte_fifo u_tx_fifo (
    .clk       (clk),
    .rst       (rst),
    .i_wr_data (i_tx_data),
    .i_wr      (i_tx_write),
    .i_rd      (tx_fifo_rd),
    .o_rd_data (tx_fifo_data),
    .o_empty   (tx_fifo_empty),
    .o_full    (o_tx_full),
    .o_level   (o_tx_level)
  );

  uart_tx u_tx (
    .clk          (clk),
    .rst          (rst),
    .i_clkdiv     (i_clkdiv),
    .i_fifo_empty (tx_fifo_empty),
    .i_fifo_data  (tx_fifo_data),
    .o_fifo_rd    (tx_fifo_rd),
    .o_txd        (o_txd)
  );

  // receive path, the receiver writes and the host reads
  uart_rx u_rx (
    .clk         (clk),
    .rst         (rst),
    .i_clkdiv    (i_clkdiv),
    .i_rxd       (i_rxd),
    .i_fifo_full (rx_fifo_full),
    .o_fifo_wr   (rx_fifo_wr),
    .o_fifo_data (rx_fifo_data)
  );

  byte_fifo u_rx_fifo (
    .clk       (clk),
    .rst       (rst),
    .i_wr_data (rx_fifo_data),
    .i_wr      (rx_fifo_wr),
    .i_rd      (i_rx_read),
    .o_rd_data (o_rx_data),
    .o_empty   (o_rx_empty),
    .o_full    (rx_fifo_full),
    .o_level   (o_rx_level)
  );

endmodule

// File: source/uart_tx.sv
// serial transmitter, 8N1 framing with each bit held for i_clkdiv clocks
// pops bytes from its FIFO and sends frames back to back while bytes are waiting

`timescale 1ns/1ps

module uart_tx
  import uart_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic [CLKDIV_W-1:0] i_clkdiv,
  input  logic                i_fifo_empty,
  input  logic [DATA_W-1:0]   i_fifo_data,
  output logic                o_fifo_rd,
  output logic                o_txd
);

  tx_state_t           state;
  logic [CLKDIV_W-1:0] baud_ctr;
  logic [BITCNT_W-1:0] bit_ctr;
  logic [DATA_W-1:0]   sr;
  logic                txd_q;
  logic                bit_end;
  logic                load;

  assign bit_end = (state != TX_IDLE) && (baud_ctr >= i_clkdiv);

  // a new byte is taken when idle or right at the end of a stop bit
  assign load      = !i_fifo_empty && ((state == TX_IDLE) || ((state == TX_STOP) && bit_end));
  assign o_fifo_rd = load;

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= TX_IDLE;
      baud_ctr <= '0;
      bit_ctr  <= '0;
      txd_q    <= 1'b1;
    end else if (load) begin
      state    <= TX_START;
      baud_ctr <= CLKDIV_W'(1);
      bit_ctr  <= '0;
      txd_q    <= 1'b0;
    end else begin
      case (state)
        TX_START: begin
          if (bit_end) begin
            state    <= TX_DATA;
            baud_ctr <= CLKDIV_W'(1);
            txd_q    <= sr[0];
          end else begin
            baud_ctr <= baud_ctr + 1'b1;
          end
        end
        TX_DATA: begin
          if (bit_end) begin
            baud_ctr <= CLKDIV_W'(1);
            if (bit_ctr == BITCNT_W'(DATA_W - 1)) begin
              state <= TX_STOP;
              txd_q <= 1'b1;
            end else begin
              bit_ctr <= bit_ctr + 1'b1;
              txd_q   <= sr[0];
            end
          end else begin
            baud_ctr <= baud_ctr + 1'b1;
          end
        end
        TX_STOP: begin
          // no byte waiting at the end of the stop bit, line stays high
          if (bit_end) begin
            state    <= TX_IDLE;
            baud_ctr <= '0;
          end else begin
            baud_ctr <= baud_ctr + 1'b1;
          end
        end
        default: begin
          state <= TX_IDLE;
          txd_q <= 1'b1;
        end
      endcase
    end
  end

  // the next data bit always sits in sr[0], LSB goes out first
  always_ff @(posedge clk) begin
    if (load) begin
      sr <= i_fifo_data;
    end else if (bit_end && ((state == TX_START) || (state == TX_DATA))) begin
      sr <= sr >> 1;
    end
  end

  assign o_txd = txd_q;

endmodule
